// ==== build.f ====
verilog/rx_ctrl_pkg.sv
verilog/sync_fifo.sv
verilog/rx_cmd_regs.sv
verilog/rx_sequencer.sv
verilog/rx_timed_ctrl.sv
test/rx_timed_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator; exits non-zero on failure
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module rx_timed_tb \
   -f build.f -o rx_timed_sim > build.log 2>&1 \
   && ./obj_dir/rx_timed_sim > sim.log 2>&1 \
   || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log \
   && { echo "Simulation failed"; exit 1; } \
   || grep -q "Simulation finished: PASS" sim.log \
   && { echo "Simulation passed"; exit 0; } \
   || { echo "No result in sim.log"; exit 1; }

// ==== test/rx_timed_tb.sv ====
// ============================================================================
// Self-checking testbench for the timed receive control block.
// Time counts up by one per clock; the DSP model strobes on random cycles.
// Expected entries are queued by a monitor that follows run_o and strobe_i.
// The overrun model assumes the sample queue holds only sample entries.
// ============================================================================
`timescale 1ns/100ps
`default_nettype none

module rx_timed_tb;
   import rx_ctrl_pkg::*;

   localparam int SW           = 32;
   localparam int CMD_DEPTH    = 16;
   localparam int SAMPLE_DEPTH = 16;
   localparam int EW           = FLAGS_W + TIME_W + SW;
   // Cycle budget per test, summed for the watchdog
   localparam int TEST_CYCLES  = 400 + 150 + 100 + 50 + 150 + 80 + 150 + 50 + 250;
   localparam int MARGIN       = 500;

   logic                clk;
   logic                rst_i;
   logic                wb_cyc_i;
   logic                wb_stb_i;
   logic                wb_we_i;
   logic [1:0]          wb_adr_i;
   logic [31:0]         wb_dat_i;
   logic [31:0]         wb_dat_o;
   logic                wb_ack_o;
   logic [TIME_W-1:0]   time_i;
   logic                strobe_i;
   logic [SW-1:0]       sample_i;
   logic                run_o;
   logic                overrun_o;
   logic [EW-1:0]       entry_o;
   logic                entry_valid_o;
   logic                entry_ready_i;

   // Scoreboard and stream model
   logic [FLAGS_W-1:0]  exp_flags[$];
   logic [TIME_W-1:0]   exp_time[$];
   logic [SW-1:0]       exp_sample[$];
   bit                  exp_is_sample[$];
   logic [FLAGS_W-1:0]  tail_q[$];
   bit                  strobe_en;
   bit                  stream_active;
   bit                  done_last;
   logic [TIME_W-1:0]   stream_start;
   int                  total_lines;
   int                  line_idx;
   int                  pause_at;
   int                  occ;
   logic [31:0]         rnd;
   logic [TIME_W-1:0]   t0;

   rx_timed_ctrl #(
      .SAMPLE_W     (SW),
      .CMD_DEPTH    (CMD_DEPTH),
      .SAMPLE_DEPTH (SAMPLE_DEPTH)
   ) uut (
      .clk           (clk),
      .rst_i         (rst_i),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_we_i       (wb_we_i),
      .wb_adr_i      (wb_adr_i),
      .wb_dat_i      (wb_dat_i),
      .wb_dat_o      (wb_dat_o),
      .wb_ack_o      (wb_ack_o),
      .time_i        (time_i),
      .strobe_i      (strobe_i),
      .sample_i      (sample_i),
      .run_o         (run_o),
      .overrun_o     (overrun_o),
      .entry_o       (entry_o),
      .entry_valid_o (entry_valid_o),
      .entry_ready_i (entry_ready_i)
   );

   always #5 clk = ~clk;

   task automatic abort_run(input string msg);
      $display("Error at %0t: %s", $time, msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   task automatic value_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped");
   endtask

   // Ack comes one cycle after the request and lasts exactly one cycle
   ack_after_req: assert property (@(posedge clk) disable iff (rst_i)
      (wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
      else abort_run("ack missing one cycle after the request");
   ack_one_cycle: assert property (@(posedge clk) disable iff (rst_i)
      wb_ack_o |=> !wb_ack_o)
      else abort_run("ack held longer than one cycle");
   ack_needs_req: assert property (@(posedge clk) disable iff (rst_i)
      !(wb_cyc_i && wb_stb_i) |=> !wb_ack_o)
      else abort_run("ack without a request");

   // Time source and DSP model
   always @(posedge clk)
   begin
      #1;
      time_i   <= time_i + 64'd1;
      rnd       = $urandom;
      strobe_i <= strobe_en & rnd[0];
      sample_i <= $urandom;
   end

   task automatic push_expected(input logic [FLAGS_W-1:0] f, input logic [TIME_W-1:0] t,
                                input logic [SW-1:0] s, input bit is_sample);
      exp_flags.push_back(f);
      exp_time.push_back(t);
      exp_sample.push_back(s);
      exp_is_sample.push_back(is_sample);
   endtask

   task automatic check_entry();
      logic [FLAGS_W-1:0] f;
      logic [TIME_W-1:0]  t;
      logic [SW-1:0]      s;
      bit                 is_s;
      if (exp_flags.size() == 0)
      begin
         abort_run("entry popped with no entry expected");
      end
      else
      begin
         f    = exp_flags.pop_front();
         t    = exp_time.pop_front();
         s    = exp_sample.pop_front();
         is_s = exp_is_sample.pop_front();
         assert (entry_o[EW-1 -: FLAGS_W] == f)
            else value_mismatch("entry_o.flags", 64'(entry_o[EW-1 -: FLAGS_W]), 64'(f));
         if (is_s)
         begin
            occ = occ - 1;
            assert (entry_o[SW +: TIME_W] == t)
               else value_mismatch("entry_o.time", entry_o[SW +: TIME_W], t);
            assert (entry_o[SW-1:0] == s)
               else value_mismatch("entry_o.sample", 64'(entry_o[SW-1:0]), 64'(s));
         end
      end
   endtask

   // Monitor builds the expected stream, then checks the sink side
   always @(posedge clk)
   begin
      if (!rst_i)
      begin
         if (run_o && !stream_active)
         begin
            abort_run("run_o high outside of a stream");
         end
         if (run_o && time_i < stream_start)
         begin
            abort_run("run_o high before the start time");
         end
         if (run_o && strobe_i)
         begin
            if (occ == SAMPLE_DEPTH)
            begin
               push_expected(5'b1 << FLAG_OVERRUN, '0, '0, 1'b0);
               stream_active = 1'b0;
            end
            else
            begin
               push_expected((done_last && line_idx == total_lines - 1) ?
                             5'b1 << FLAG_DONE : 5'b0, time_i, sample_i, 1'b1);
               occ      = occ + 1;
               line_idx = line_idx + 1;
               if (line_idx == pause_at)
               begin
                  strobe_en = 1'b0;
               end
               if (line_idx == total_lines)
               begin
                  stream_active = 1'b0;
                  while (tail_q.size() > 0)
                  begin
                     push_expected(tail_q.pop_front(), '0, '0, 1'b0);
                  end
               end
            end
         end
         if (entry_valid_o && entry_ready_i)
         begin
            check_entry();
         end
      end
   end

   task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdata);
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      wb_we_i  = we;
      wb_adr_i = adr;
      wb_dat_i = dat;
      @(posedge clk);
      #1;
      if (!wb_ack_o)
      begin
         abort_run("no ack one cycle after the strobe");
      end
      rdata = wb_dat_o;
      @(posedge clk);
      #1;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic bus_write(input logic [1:0] adr, input logic [31:0] dat);
      logic [31:0] dummy;
      bus_cycle(1'b1, adr, dat, dummy);
   endtask

   task automatic bus_read_check(input logic [1:0] adr, input logic [31:0] exp,
                                 input string name);
      logic [31:0] got;
      bus_cycle(1'b0, adr, 32'd0, got);
      assert (got == exp) else value_mismatch(name, 64'(got), 64'(exp));
   endtask

   task automatic send_cmd(input bit imm, input bit chain, input bit reload,
                           input logic [LINES_W-1:0] lines, input logic [TIME_W-1:0] start);
      bus_write(REG_CMD, {imm, chain, reload, lines});
      bus_write(REG_TIME_HI, start[63:32]);
      bus_write(REG_TIME_LO, start[31:0]);
   endtask

   task automatic start_stream(input logic [TIME_W-1:0] start, input int lines,
                               input bit done_flag, input int pause);
      stream_start  = start;
      total_lines   = lines;
      done_last     = done_flag;
      pause_at      = pause;
      line_idx      = 0;
      stream_active = 1'b1;
   endtask

   task automatic wait_drained();
      while (stream_active || exp_flags.size() != 0)
      begin
         @(posedge clk);
         #1;
      end
      repeat (4) @(posedge clk);
      #1;
      strobe_en = 1'b0;
   endtask

   initial
   begin
      #((TEST_CYCLES + MARGIN) * 10);
      $display("Error at %0t: watchdog expired, the tests did not finish", $time);
      $display("Simulation finished: FAIL");
      $fatal(1, "watchdog");
   end

   initial
   begin
      void'($urandom(32'h994f_f5bd));
      clk           = 1'b0;
      rst_i         = 1'b1;
      wb_cyc_i      = 1'b0;
      wb_stb_i      = 1'b0;
      wb_we_i       = 1'b0;
      wb_adr_i      = '0;
      wb_dat_i      = '0;
      time_i        = '0;
      strobe_i      = 1'b0;
      sample_i      = '0;
      entry_ready_i = 1'b1;
      strobe_en     = 1'b0;
      stream_active = 1'b0;
      done_last     = 1'b0;
      stream_start  = '0;
      total_lines   = 0;
      line_idx      = 0;
      pause_at      = 0;
      occ           = 0;
      repeat (4) @(posedge clk);
      #1;
      rst_i = 1'b0;
      if (wb_ack_o || run_o || overrun_o || entry_valid_o)
      begin
         abort_run("outputs not low after reset");
      end

      // Register readback; the zero-line command yields a zero-length entry
      push_expected(5'b1 << FLAG_ZEROLEN, '0, '0, 1'b0);
      send_cmd(1'b0, 1'b1, 1'b1, 29'd0, 64'h1234_5678_9abc_def0);
      bus_read_check(REG_CMD, 32'h6000_0000, "wb_dat_o (cmd)");
      bus_read_check(REG_TIME_HI, 32'h1234_5678, "wb_dat_o (time_hi)");
      bus_read_check(REG_TIME_LO, 32'h9abc_def0, "wb_dat_o (time_lo)");
      wait_drained();

      // Overfill with the head command waiting, 16 filling the queue and one lost
      t0 = time_i + 64'd200;
      start_stream(t0, 1, 1'b1, 0);
      repeat (16) tail_q.push_back(5'b1 << FLAG_ZEROLEN);
      strobe_en = 1'b1;
      send_cmd(1'b0, 1'b0, 1'b0, 29'd1, t0);
      repeat (17) send_cmd(1'b0, 1'b0, 1'b0, 29'd0, 64'd0);
      bus_read_check(REG_STATUS, 32'h0001_1001, "wb_dat_o (status, lost)");
      bus_write(REG_STATUS, 32'd0);
      bus_read_check(REG_STATUS, 32'h0000_1001, "wb_dat_o (status, cleared)");
      wait_drained();

      // Timed start
      t0 = time_i + 64'd40;
      start_stream(t0, 4, 1'b1, 0);
      strobe_en = 1'b1;
      send_cmd(1'b0, 1'b0, 1'b0, 29'd4, t0);
      wait_drained();

      // Send immediately with a far start time
      start_stream(time_i, 3, 1'b1, 0);
      strobe_en = 1'b1;
      send_cmd(1'b1, 1'b0, 1'b0, 29'd3, 64'hffff_ffff_0000_0000);
      wait_drained();

      // Late command that yields no samples
      push_expected(5'b1 << FLAG_LATE, '0, '0, 1'b0);
      strobe_en = 1'b1;
      send_cmd(1'b0, 1'b0, 1'b0, 29'd5, time_i - 64'd10);
      wait_drained();

      // Two chained commands give one continuous stream
      t0 = time_i + 64'd60;
      start_stream(t0, 5, 1'b1, 0);
      strobe_en = 1'b1;
      send_cmd(1'b0, 1'b1, 1'b0, 29'd3, t0);
      send_cmd(1'b0, 1'b0, 1'b0, 29'd2, 64'd0);
      wait_drained();

      // Broken chain
      start_stream(time_i, 2, 1'b0, 0);
      tail_q.push_back(5'b1 << FLAG_BROKEN);
      strobe_en = 1'b1;
      send_cmd(1'b1, 1'b1, 1'b0, 29'd2, 64'd0);
      wait_drained();

      // Reload runs two rounds, then a new command takes over after round three
      start_stream(time_i, 9, 1'b1, 4);
      strobe_en = 1'b1;
      send_cmd(1'b1, 1'b1, 1'b1, 29'd2, 64'd0);
      while (strobe_en)
      begin
         @(posedge clk);
         #1;
      end
      send_cmd(1'b0, 1'b0, 1'b0, 29'd3, 64'd0);
      strobe_en = 1'b1;
      wait_drained();

      // Overrun with the sink stalled
      entry_ready_i = 1'b0;
      occ = 0;
      start_stream(time_i, 40, 1'b1, 0);
      strobe_en = 1'b1;
      send_cmd(1'b1, 1'b0, 1'b0, 29'd40, 64'd0);
      while (!overrun_o)
      begin
         @(posedge clk);
         #1;
      end
      if (occ != SAMPLE_DEPTH || run_o)
      begin
         abort_run("overrun_o raised before the sample queue was full");
      end
      entry_ready_i = 1'b1;
      wait_drained();
      if (overrun_o)
      begin
         abort_run("overrun_o still high after the overrun entry");
      end

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/rx_timed_ctrl.sv ====
// ==========================================================================
// Timed receive control, top level.
// Software queues stream commands over Wishbone; the sequencer gates the
// DSP strobe by time and fills the sample queue that the framer drains.
// Entry layout from the top: flags, 64-bit time stamp, sample.
// The status register reports at most 8 bits of command queue count.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module rx_timed_ctrl
   import rx_ctrl_pkg::*;
#(
   parameter int SAMPLE_W     = 32,
   parameter int CMD_DEPTH    = 16,
   parameter int SAMPLE_DEPTH = 16
) (
   input  wire                                 clk,
   input  wire                                 rst_i,
   input  wire                                 wb_cyc_i,
   input  wire                                 wb_stb_i,
   input  wire                                 wb_we_i,
   input  wire  [1:0]                          wb_adr_i,
   input  wire  [31:0]                         wb_dat_i,
   output logic [31:0]                         wb_dat_o,
   output logic                                wb_ack_o,
   input  wire  [TIME_W-1:0]                   time_i,
   input  wire                                 strobe_i,
   input  wire  [SAMPLE_W-1:0]                 sample_i,
   output logic                                run_o,
   output logic                                overrun_o,
   output logic [FLAGS_W+TIME_W+SAMPLE_W-1:0]  entry_o,
   output logic                                entry_valid_o,
   input  wire                                 entry_ready_i
);

   typedef struct packed {
      logic [FLAGS_W-1:0]  flags;
      logic [TIME_W-1:0]   stamp;
      logic [SAMPLE_W-1:0] sample;
   } entry_t;

   rx_cmd_t                          reg_cmd;
   logic                             reg_push;
   logic                             reg_ready;
   logic [$clog2(CMD_DEPTH+1)-1:0]   cmd_count;
   rx_cmd_t                          head_cmd;
   logic                             head_valid;
   logic                             head_ready;
   seq_state_t                       seq_state;
   entry_t                           seq_entry;
   logic                             seq_valid;
   logic                             seq_ready;
   entry_t                           out_entry;

   rx_cmd_regs #(
      .CMD_DEPTH (CMD_DEPTH)
   ) u_regs (
      .clk         (clk),
      .rst_i       (rst_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_dat_o    (wb_dat_o),
      .wb_ack_o    (wb_ack_o),
      .cmd_o       (reg_cmd),
      .cmd_push_o  (reg_push),
      .cmd_ready_i (reg_ready),
      .cmd_count_i (cmd_count),
      .state_i     (seq_state)
   );

   // Command queue
   sync_fifo #(
      .payload_t (rx_cmd_t),
      .DEPTH     (CMD_DEPTH)
   ) u_cmd_fifo (
      .clk          (clk),
      .rst_i        (rst_i),
      .push_data_i  (reg_cmd),
      .push_valid_i (reg_push),
      .push_ready_o (reg_ready),
      .pop_data_o   (head_cmd),
      .pop_valid_o  (head_valid),
      .pop_ready_i  (head_ready),
      .count_o      (cmd_count)
   );

   rx_sequencer #(
      .SAMPLE_W (SAMPLE_W)
   ) u_seq (
      .clk           (clk),
      .rst_i         (rst_i),
      .cmd_i         (head_cmd),
      .cmd_valid_i   (head_valid),
      .cmd_ready_o   (head_ready),
      .time_i        (time_i),
      .strobe_i      (strobe_i),
      .sample_i      (sample_i),
      .run_o         (run_o),
      .overrun_o     (overrun_o),
      .state_o       (seq_state),
      .entry_data_o  (seq_entry),
      .entry_valid_o (seq_valid),
      .entry_ready_i (seq_ready)
   );

   // Sample queue towards the framer
   sync_fifo #(
      .payload_t (entry_t),
      .DEPTH     (SAMPLE_DEPTH)
   ) u_sample_fifo (
      .clk          (clk),
      .rst_i        (rst_i),
      .push_data_i  (seq_entry),
      .push_valid_i (seq_valid),
      .push_ready_o (seq_ready),
      .pop_data_o   (out_entry),
      .pop_valid_o  (entry_valid_o),
      .pop_ready_i  (entry_ready_i),
      .count_o      ()
   );

   assign entry_o = out_entry;

endmodule

`default_nettype wire

// ==== verilog/rx_sequencer.sv ====
// ==========================================================================
// Timed receive sequencer.
// Takes the head command while idle, waits for its start time (or starts
// at once for send_imm) and passes DSP strobes into the sample queue.
// Start is exact: time_i must step through start_time or the command
// is reported late. Reload only applies to chained commands.
// Flag-only entries carry a zero sample and the time of the write.
// A strobe that meets a full queue is lost and ends the stream.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module rx_sequencer
   import rx_ctrl_pkg::*;
#(
   parameter int SAMPLE_W = 32
) (
   input  wire                                    clk,
   input  wire                                    rst_i,
   input  wire rx_cmd_t                           cmd_i,
   input  wire                                    cmd_valid_i,
   output logic                                   cmd_ready_o,
   input  wire  [TIME_W-1:0]                      time_i,
   input  wire                                    strobe_i,
   input  wire  [SAMPLE_W-1:0]                    sample_i,
   output logic                                   run_o,
   output logic                                   overrun_o,
   output seq_state_t                             state_o,
   output logic [FLAGS_W+TIME_W+SAMPLE_W-1:0]     entry_data_o,
   output logic                                   entry_valid_o,
   input  wire                                    entry_ready_i
);

   seq_state_t          state_q;
   rx_cmd_t             cur_q;
   logic [LINES_W-1:0]  lines_left_q;
   logic                time_now;
   logic                time_late;
   logic                go;
   logic                too_late;
   logic                full;
   logic                last_line;
   logic                next_zero;
   logic [FLAGS_W-1:0]  flags;
   logic [SAMPLE_W-1:0] entry_sample;

   // Time compare against the loaded command
   assign time_now  = (time_i == cur_q.start_time);
   assign time_late = (time_i > cur_q.start_time);
   assign go        = time_now | cur_q.send_imm;
   assign too_late  = time_late & ~cur_q.send_imm;

   assign full      = ~entry_ready_i;
   assign last_line = (lines_left_q == LINES_W'(1));
   // A queued zero-line command tells a chain to stop here
   assign next_zero = cmd_valid_i & (cmd_i.num_lines == '0);

   assign run_o     = (state_q == RUNNING);
   assign overrun_o = (state_q == OVERRUN);
   assign state_o   = state_q;

   always_comb
   begin
      flags = '0;
      // Done unless the stream continues seamlessly into more lines
      flags[FLAG_DONE]    = run_o & last_line & (~cur_q.chain | next_zero);
      flags[FLAG_LATE]    = (state_q == LATE_CMD);
      flags[FLAG_BROKEN]  = (state_q == BROKEN_CHAIN);
      flags[FLAG_OVERRUN] = (state_q == OVERRUN);
      flags[FLAG_ZEROLEN] = (state_q == ZERO_LEN);
   end

   always_comb
   begin
      case (state_q)
         RUNNING:      entry_valid_o = strobe_i;
         OVERRUN,
         BROKEN_CHAIN,
         LATE_CMD,
         ZERO_LEN:     entry_valid_o = 1'b1;
         default:      entry_valid_o = 1'b0;
      endcase
   end

   assign entry_sample = run_o ? sample_i : '0;
   assign entry_data_o = {flags, time_i, entry_sample};

   // Pop while idle, or at the last line of a chained command
   assign cmd_ready_o = cmd_valid_i &
                        ((state_q == IDLE) |
                         (run_o & strobe_i & ~full & last_line & cur_q.chain));

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         state_q      <= IDLE;
         cur_q        <= '0;
         lines_left_q <= '0;
      end
      else
      begin
         case (state_q)
            IDLE:
            begin
               if (cmd_valid_i)
               begin
                  cur_q        <= cmd_i;
                  lines_left_q <= cmd_i.num_lines;
                  state_q      <= (cmd_i.num_lines == '0) ? ZERO_LEN : WAITING;
               end
            end
            WAITING:
            begin
               if (go)
               begin
                  state_q <= RUNNING;
               end
               else if (too_late)
               begin
                  state_q <= LATE_CMD;
               end
            end
            RUNNING:
            begin
               if (strobe_i & full)
               begin
                  state_q <= OVERRUN;
               end
               else if (strobe_i)
               begin
                  lines_left_q <= lines_left_q - 1'b1;
                  if (last_line)
                  begin
                     if (~cur_q.chain)
                     begin
                        state_q <= IDLE;
                     end
                     else if (cmd_valid_i)
                     begin
                        // Next command follows without a new time check
                        cur_q        <= cmd_i;
                        lines_left_q <= cmd_i.num_lines;
                        if (next_zero)
                        begin
                           state_q <= IDLE;
                        end
                     end
                     else if (cur_q.reload)
                     begin
                        lines_left_q <= cur_q.num_lines;
                     end
                     else
                     begin
                        state_q <= BROKEN_CHAIN;
                     end
                  end
               end
            end
            OVERRUN,
            BROKEN_CHAIN,
            LATE_CMD,
            ZERO_LEN:
            begin
               // Flag entry goes out once the queue has room
               if (entry_ready_i)
               begin
                  state_q <= IDLE;
               end
            end
            default:
            begin
               state_q <= IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/rx_cmd_regs.sv ====
// ==========================================================================
// Wishbone classic slave holding the receive command registers.
// Ack rises one cycle after cyc/stb and lasts exactly one cycle; the
// master must hold its request until ack. Writes take effect in the
// ack cycle. A time-low write pushes {command, time-high, wb_dat_i}
// into the command queue; if the queue is full the command is dropped
// and cmd_lost is set until software writes the status register.
// Status: [2:0] sequencer state, [15:8] queue count, [16] cmd_lost.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module rx_cmd_regs
   import rx_ctrl_pkg::*;
#(
   parameter int CMD_DEPTH = 16
) (
   input  wire                              clk,
   input  wire                              rst_i,
   input  wire                              wb_cyc_i,
   input  wire                              wb_stb_i,
   input  wire                              wb_we_i,
   input  wire  [1:0]                       wb_adr_i,
   input  wire  [31:0]                      wb_dat_i,
   output logic [31:0]                      wb_dat_o,
   output logic                             wb_ack_o,
   output rx_cmd_t                          cmd_o,
   output logic                             cmd_push_o,
   input  wire                              cmd_ready_i,
   input  wire  [$clog2(CMD_DEPTH+1)-1:0]   cmd_count_i,
   input  wire seq_state_t                  state_i
);

   logic          ack_q;
   logic [31:0]   cmd_q;
   logic [31:0]   time_hi_q;
   logic [31:0]   time_lo_q;
   logic          cmd_lost_q;
   logic          req;
   logic          wr_en;
   logic [7:0]    count_b;
   logic [31:0]   status;
   logic [31:0]   rd_mux;

   assign req      = wb_cyc_i & wb_stb_i;
   assign wr_en    = ack_q & req & wb_we_i;
   assign wb_ack_o = ack_q;

   assign count_b = 8'(cmd_count_i);
   assign status  = {15'd0, cmd_lost_q, count_b, 5'd0, state_i};

   // Low time word comes straight from the bus because the register updates later
   assign cmd_o      = {cmd_q, time_hi_q, wb_dat_i};
   assign cmd_push_o = wr_en & (wb_adr_i == REG_TIME_LO);

   always_comb
   begin
      case (wb_adr_i)
         REG_CMD:     rd_mux = cmd_q;
         REG_TIME_HI: rd_mux = time_hi_q;
         REG_TIME_LO: rd_mux = time_lo_q;
         default:     rd_mux = status;
      endcase
   end

   // Ack lasts one cycle and never comes back to back
   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         ack_q <= 1'b0;
      end
      else
      begin
         ack_q <= req & ~ack_q;
      end
   end

   // Read data is sampled in the request cycle and held through ack
   always_ff @(posedge clk)
   begin
      if (req & ~ack_q)
      begin
         wb_dat_o <= rd_mux;
      end
   end

   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         cmd_q      <= '0;
         time_hi_q  <= '0;
         time_lo_q  <= '0;
         cmd_lost_q <= 1'b0;
      end
      else
      begin
         if (wr_en)
         begin
            case (wb_adr_i)
               REG_CMD:     cmd_q <= wb_dat_i;
               REG_TIME_HI: time_hi_q <= wb_dat_i;
               REG_TIME_LO: time_lo_q <= wb_dat_i;
               default:     cmd_lost_q <= 1'b0;
            endcase
         end
         // Command dropped because the queue is full
         if (cmd_push_o & ~cmd_ready_i)
         begin
            cmd_lost_q <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/sync_fifo.sv ====
// ==========================================================================
// Synchronous FIFO with a type-parameter payload.
// Valid/ready on both sides; a word moves when both are high.
// Pop data comes straight from the storage array, so a word pushed at
// a rising edge is visible on the pop side in the next cycle.
// Push while full and pop while empty are refused through the ready
// and valid outputs.
// ==========================================================================
`timescale 1ns/100ps
`default_nettype none

module sync_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int  DEPTH     = 16
) (
   input  wire                          clk,
   input  wire                          rst_i,
   input  wire payload_t                push_data_i,
   input  wire                          push_valid_i,
   output logic                         push_ready_o,
   output payload_t                     pop_data_o,
   output logic                         pop_valid_o,
   input  wire                          pop_ready_i,
   output logic [$clog2(DEPTH+1)-1:0]   count_o
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   payload_t        mem [DEPTH];
   logic [AW-1:0]   wr_ptr_q;
   logic [AW-1:0]   rd_ptr_q;
   logic [CW-1:0]   count_q;
   logic            push_fire;
   logic            pop_fire;

   assign push_ready_o = (count_q != CW'(DEPTH));
   assign pop_valid_o  = (count_q != '0);
   assign push_fire    = push_valid_i & push_ready_o;
   assign pop_fire     = pop_valid_o & pop_ready_i;
   assign pop_data_o   = mem[rd_ptr_q];
   assign count_o      = count_q;

   always_ff @(posedge clk)
   begin
      if (push_fire)
      begin
         mem[wr_ptr_q] <= push_data_i;
      end
   end

   // Pointers wrap explicitly so DEPTH need not be a power of two
   always_ff @(posedge clk)
   begin
      if (rst_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push_fire)
         begin
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop_fire)
         begin
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         if (push_fire & ~pop_fire)
         begin
            count_q <= count_q + 1'b1;
         end
         else if (pop_fire & ~push_fire)
         begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== verilog/rx_ctrl_pkg.sv ====
// ==========================================================================
// Shared types and constants for the timed receive control block.
// A command is 96 bits wide: three flag bits, a 29-bit line count and
// a 64-bit start time. The command register word holds the upper 32 bits.
// Sample entries carry FLAGS_W flag bits above the time stamp.
// ==========================================================================
`default_nettype none

package rx_ctrl_pkg;

   localparam int TIME_W  = 64;
   localparam int FLAGS_W = 5;
   localparam int LINES_W = 29;

   // Command as queued; the top word matches the command register
   typedef struct packed {
      logic               send_imm;
      logic               chain;
      logic               reload;
      logic [LINES_W-1:0] num_lines;
      logic [TIME_W-1:0]  start_time;
   } rx_cmd_t;

   // Error states keep bit 2 set
   typedef enum logic [2:0] {
      IDLE         = 3'd0,
      WAITING      = 3'd1,
      RUNNING      = 3'd2,
      OVERRUN      = 3'd4,
      BROKEN_CHAIN = 3'd5,
      LATE_CMD     = 3'd6,
      ZERO_LEN     = 3'd7
   } seq_state_t;

   // Bit positions inside the entry flag field
   localparam int FLAG_DONE    = 0;
   localparam int FLAG_LATE    = 1;
   localparam int FLAG_BROKEN  = 2;
   localparam int FLAG_OVERRUN = 3;
   localparam int FLAG_ZEROLEN = 4;

   // Wishbone word offsets
   localparam logic [1:0] REG_CMD     = 2'd0;
   localparam logic [1:0] REG_TIME_HI = 2'd1;
   localparam logic [1:0] REG_TIME_LO = 2'd2;
   localparam logic [1:0] REG_STATUS  = 2'd3;

endpackage

`default_nettype wire
